// ==== Makefile ====
# Verilator build and run for the SoC AXI4 switch testbench

TOP = tb_soc_axi_switch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/axi_switch_macros.svh ====
// Bus widths and slave count for the one-master, three-slave AXI4 switch.
// Include this wherever a port or a lane slice is sized.
`ifndef AXI_SWITCH_MACROS_SVH
`define AXI_SWITCH_MACROS_SVH

// master side field widths
`define AXI_ID_W     4
`define AXI_ADDR_W   64
`define AXI_DATA_W   64
`define AXI_STRB_W   8

// burst control
`define AXI_LEN_W    8
`define AXI_SIZE_W   3
`define AXI_BURST_W  2

`define AXI_RESP_W   2

// lane 0 is IO, lane 1 is the timer, lane 2 is memory
`define SLAVE_NUM    3

`endif

// ==== common/axi_switch_pkg.sv ====
// Types and the select decoder shared by the AXI switch routers.
// Import into any module that decodes a select or drives a response.
`default_nettype none

`include "axi_switch_macros.svh"

package axi_switch_pkg;

    // decoded target, the value doubles as the lane index
    typedef enum logic [1:0] {
        SEL_IO    = 2'd0,
        SEL_TIMER = 2'd1,
        SEL_MEM   = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_e;

    typedef enum logic [`AXI_RESP_W-1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // lowest set bit wins; nothing is selected while reset is high
    function automatic slave_sel_e decode_select(
        input logic [`SLAVE_NUM-1:0] sel,
        input logic                  reset
    );
        slave_sel_e target;
        target = SEL_NONE;
        if (!reset) begin
            if (sel[0]) begin
                target = SEL_IO;
            end else if (sel[1]) begin
                target = SEL_TIMER;
            end else if (sel[2]) begin
                target = SEL_MEM;
            end
        end
        return target;
    endfunction

endpackage

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/axi_switch_pkg.sv
verilog/axi_write_router.sv
verilog/axi_read_router.sv
verilog/soc_axi_switch.sv
verification/tb_soc_axi_switch.sv

// ==== verification/tb_soc_axi_switch.sv ====
// Random stimulus testbench for the SoC AXI4 switch with modeled slave lanes.
// A reference model predicts every DUT output and is compared each rising edge.
`timescale 1ns/1ns
`default_nettype none

`include "axi_switch_macros.svh"

module tb_soc_axi_switch
    import axi_switch_pkg::*;
;

    localparam int TEST_CYCLES = 200;
    localparam int NUM_TESTS   = 6;
    localparam int MAX_CYCLES  = NUM_TESTS * TEST_CYCLES + 800;

    logic clk;
    logic reset;
    logic [`SLAVE_NUM-1:0] write_select, read_select;
    logic [`AXI_ID_W-1:0] aw_id, ar_id, b_id, r_id;
    logic [`AXI_ADDR_W-1:0] aw_addr, ar_addr;
    logic [`AXI_LEN_W-1:0] aw_len, ar_len;
    logic [`AXI_SIZE_W-1:0] aw_size, ar_size;
    logic [`AXI_BURST_W-1:0] aw_burst, ar_burst;
    logic [`AXI_DATA_W-1:0] w_data, r_data;
    logic [`AXI_STRB_W-1:0] w_strb;
    logic [`AXI_RESP_W-1:0] b_resp, r_resp;
    logic aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_last, r_valid, r_ready;
    logic [`AXI_ID_W*`SLAVE_NUM-1:0] slave_aw_id, slave_ar_id, slave_b_id, slave_r_id;
    logic [`AXI_ADDR_W*`SLAVE_NUM-1:0] slave_aw_addr, slave_ar_addr;
    logic [`AXI_LEN_W*`SLAVE_NUM-1:0] slave_aw_len, slave_ar_len;
    logic [`AXI_SIZE_W*`SLAVE_NUM-1:0] slave_aw_size, slave_ar_size;
    logic [`AXI_BURST_W*`SLAVE_NUM-1:0] slave_aw_burst, slave_ar_burst;
    logic [`AXI_DATA_W*`SLAVE_NUM-1:0] slave_w_data, slave_r_data;
    logic [`AXI_STRB_W*`SLAVE_NUM-1:0] slave_w_strb;
    logic [`AXI_RESP_W*`SLAVE_NUM-1:0] slave_b_resp, slave_r_resp;
    logic [`SLAVE_NUM-1:0] slave_aw_valid, slave_aw_ready, slave_w_last, slave_w_valid;
    logic [`SLAVE_NUM-1:0] slave_w_ready, slave_b_valid, slave_b_ready;
    logic [`SLAVE_NUM-1:0] slave_ar_valid, slave_ar_ready, slave_r_last, slave_r_valid;
    logic [`SLAVE_NUM-1:0] slave_r_ready;

    logic [31:0] rng;
    int errors, checks, test_errors, cycles;
    int wl, rl;
    bit checking;
    string test_names [1:6] = '{"write routing", "write return path", "read routing",
                                "priority", "default sink", "independent selects"};

    soc_axi_switch i_soc_axi_switch (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [63:0] v);
        rng = xorshift(rng);
        v[63:32] = rng;
        rng = xorshift(rng);
        v[31:0] = rng;
    endtask

    // reference lane is the lowest set select bit, or -1 in reset or with no bit set
    function automatic int pick_lane(input logic [2:0] sel, input logic rst);
        int lane;
        lane = -1;
        if (!rst) begin
            for (int i = 2; i >= 0; i--) begin
                if (sel[i]) lane = i;
            end
        end
        return lane;
    endfunction

    // expected slave-side bus holds the field in its lane and zeros elsewhere
    function automatic logic [255:0] spread(input logic [255:0] val, input int width,
                                            input int lane);
        logic [255:0] mask;
        mask = (256'd1 << width) - 1;
        if (lane < 0) return '0;
        return (val & mask) << (lane * width);
    endfunction

    // expected master-side value comes from the selected lane or the sink
    function automatic logic [255:0] gather(input logic [255:0] vec, input int width,
                                            input int lane, input logic [255:0] dflt);
        logic [255:0] mask;
        mask = (256'd1 << width) - 1;
        if (lane < 0) return dflt;
        return (vec >> (lane * width)) & mask;
    endfunction

    task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic drive_inputs(input int test_id, input int cyc);
        logic [63:0] r0, r1, r2, r3;
        logic [2:0] oh;
        int lane;
        next_rand(r0);
        next_rand(r1);
        next_rand(r2);
        next_rand(r3);
        aw_id = r0[3:0];
        aw_len = r0[11:4];
        aw_size = r0[14:12];
        aw_burst = r0[16:15];
        aw_valid = r0[17];
        ar_id = r0[21:18];
        ar_len = r0[29:22];
        ar_size = r0[32:30];
        ar_burst = r0[34:33];
        ar_valid = r0[35];
        w_strb = r0[43:36];
        w_last = r0[44];
        w_valid = r0[45];
        b_ready = r0[46];
        r_ready = r0[47];
        aw_addr = r1;
        ar_addr = r2;
        w_data = r3;
        // slave response models
        next_rand(r0);
        next_rand(r1);
        next_rand(r2);
        next_rand(r3);
        slave_aw_ready = r0[2:0];
        slave_w_ready = r0[5:3];
        slave_b_valid = r0[8:6];
        slave_ar_ready = r0[11:9];
        slave_r_last = r0[14:12];
        slave_r_valid = r0[17:15];
        slave_b_id = r0[29:18];
        slave_b_resp = r0[35:30];
        slave_r_id = r0[47:36];
        slave_r_resp = r0[53:48];
        slave_r_data = {r1, r2, r3};
        next_rand(r0);
        lane = r0[63:56] % 3;
        oh = 3'b001 << lane;
        write_select = r0[2:0];
        read_select = r0[5:3];
        reset = 1'b0;
        case (test_id)
            0: reset = 1'b1;
            1: write_select = oh;
            2: write_select = oh;
            3: read_select = oh;
            4: begin
                write_select = r0[8] ? 3'b111 : ~oh;
                read_select = r0[9] ? 3'b111 : ~(3'b001 << ((lane + 1) % 3));
            end
            5: begin
                // zero selects around a reset pulse in the middle
                if (cyc >= 80 && cyc < 120) begin
                    reset = 1'b1;
                end else begin
                    write_select = '0;
                    read_select = '0;
                end
            end
            6: begin
                write_select = oh;
                read_select = 3'b001 << ((lane + 1 + r0[10]) % 3);
            end
            default: ;
        endcase
    endtask

    always @(posedge clk) begin
        if (checking) begin
            wl = pick_lane(write_select, reset);
            rl = pick_lane(read_select, reset);
            check("aw_ready", aw_ready, gather(slave_aw_ready, 1, wl, 1));
            check("w_ready", w_ready, gather(slave_w_ready, 1, wl, 1));
            check("b_id", b_id, gather(slave_b_id, `AXI_ID_W, wl, 0));
            check("b_resp", b_resp, gather(slave_b_resp, `AXI_RESP_W, wl, OKAY));
            check("b_valid", b_valid, gather(slave_b_valid, 1, wl, 1));
            check("slave_aw_id", slave_aw_id, spread(aw_id, `AXI_ID_W, wl));
            check("slave_aw_addr", slave_aw_addr, spread(aw_addr, `AXI_ADDR_W, wl));
            check("slave_aw_len", slave_aw_len, spread(aw_len, `AXI_LEN_W, wl));
            check("slave_aw_size", slave_aw_size, spread(aw_size, `AXI_SIZE_W, wl));
            check("slave_aw_burst", slave_aw_burst, spread(aw_burst, `AXI_BURST_W, wl));
            check("slave_aw_valid", slave_aw_valid, spread(aw_valid, 1, wl));
            check("slave_w_data", slave_w_data, spread(w_data, `AXI_DATA_W, wl));
            check("slave_w_strb", slave_w_strb, spread(w_strb, `AXI_STRB_W, wl));
            check("slave_w_last", slave_w_last, spread(w_last, 1, wl));
            check("slave_w_valid", slave_w_valid, spread(w_valid, 1, wl));
            check("slave_b_ready", slave_b_ready, spread(b_ready, 1, wl));
            check("ar_ready", ar_ready, gather(slave_ar_ready, 1, rl, 1));
            check("r_id", r_id, gather(slave_r_id, `AXI_ID_W, rl, 0));
            check("r_data", r_data, gather(slave_r_data, `AXI_DATA_W, rl, 0));
            check("r_resp", r_resp, gather(slave_r_resp, `AXI_RESP_W, rl, OKAY));
            check("r_last", r_last, gather(slave_r_last, 1, rl, 1));
            check("r_valid", r_valid, gather(slave_r_valid, 1, rl, 1));
            check("slave_ar_id", slave_ar_id, spread(ar_id, `AXI_ID_W, rl));
            check("slave_ar_addr", slave_ar_addr, spread(ar_addr, `AXI_ADDR_W, rl));
            check("slave_ar_len", slave_ar_len, spread(ar_len, `AXI_LEN_W, rl));
            check("slave_ar_size", slave_ar_size, spread(ar_size, `AXI_SIZE_W, rl));
            check("slave_ar_burst", slave_ar_burst, spread(ar_burst, `AXI_BURST_W, rl));
            check("slave_ar_valid", slave_ar_valid, spread(ar_valid, 1, rl));
            check("slave_r_ready", slave_r_ready, spread(r_ready, 1, rl));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        rng = 32'h1976;
        {write_select, read_select} = '0;
        {aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_valid} = '0;
        {w_data, w_strb, w_last, w_valid, b_ready} = '0;
        {ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_valid, r_ready} = '0;
        {slave_aw_ready, slave_w_ready, slave_b_id, slave_b_resp, slave_b_valid} = '0;
        {slave_ar_ready, slave_r_id, slave_r_data, slave_r_resp} = '0;
        {slave_r_last, slave_r_valid} = '0;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            drive_inputs(0, c);
            checking = 1'b1;
        end
        for (int t = 1; t <= NUM_TESTS; t++) begin
            test_errors = 0;
            for (int c = 0; c < TEST_CYCLES; c++) begin
                @(negedge clk);
                drive_inputs(t, c);
            end
            @(negedge clk);
            $display("test %0d (%s) done: %0d errors", t, test_names[t], test_errors);
        end
        checking = 1'b0;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/axi_read_router.sv ====
// Read path of the AXI switch: steers AR to one slave lane and returns
// that lane's R beats. Purely combinational.
`timescale 1ns/1ns
`default_nettype none

`include "axi_switch_macros.svh"

module axi_read_router
    import axi_switch_pkg::*;
(
    input  wire                                   reset,
    input  wire  [`SLAVE_NUM-1:0]                 read_select,

    input  wire  [`AXI_ID_W-1:0]                  ar_id,
    input  wire  [`AXI_ADDR_W-1:0]                ar_addr,
    input  wire  [`AXI_LEN_W-1:0]                 ar_len,
    input  wire  [`AXI_SIZE_W-1:0]                ar_size,
    input  wire  [`AXI_BURST_W-1:0]               ar_burst,
    input  wire                                   ar_valid,
    output logic                                  ar_ready,

    output logic [`AXI_ID_W-1:0]                  r_id,
    output logic [`AXI_DATA_W-1:0]                r_data,
    output logic [`AXI_RESP_W-1:0]                r_resp,
    output logic                                  r_last,
    output logic                                  r_valid,
    input  wire                                   r_ready,

    output logic [`AXI_ID_W*`SLAVE_NUM-1:0]       slave_ar_id,
    output logic [`AXI_ADDR_W*`SLAVE_NUM-1:0]     slave_ar_addr,
    output logic [`AXI_LEN_W*`SLAVE_NUM-1:0]      slave_ar_len,
    output logic [`AXI_SIZE_W*`SLAVE_NUM-1:0]     slave_ar_size,
    output logic [`AXI_BURST_W*`SLAVE_NUM-1:0]    slave_ar_burst,
    output logic [`SLAVE_NUM-1:0]                 slave_ar_valid,
    input  wire  [`SLAVE_NUM-1:0]                 slave_ar_ready,

    input  wire  [`AXI_ID_W*`SLAVE_NUM-1:0]       slave_r_id,
    input  wire  [`AXI_DATA_W*`SLAVE_NUM-1:0]     slave_r_data,
    input  wire  [`AXI_RESP_W*`SLAVE_NUM-1:0]     slave_r_resp,
    input  wire  [`SLAVE_NUM-1:0]                 slave_r_last,
    input  wire  [`SLAVE_NUM-1:0]                 slave_r_valid,
    output logic [`SLAVE_NUM-1:0]                 slave_r_ready
);

    slave_sel_e target;
    logic [1:0] lane;

    assign target = decode_select(read_select, reset);
    assign lane   = target;

    always_comb begin
        slave_ar_id    = '0;
        slave_ar_addr  = '0;
        slave_ar_len   = '0;
        slave_ar_size  = '0;
        slave_ar_burst = '0;
        slave_ar_valid = '0;
        slave_r_ready  = '0;

        // with no target the master gets a single zero beat, so a stray
        // read still completes
        ar_ready = 1'b1;
        r_id     = '0;
        r_data   = '0;
        r_resp   = OKAY;
        r_last   = 1'b1;
        r_valid  = 1'b1;

        if (target != SEL_NONE) begin
            slave_ar_id[lane*`AXI_ID_W +: `AXI_ID_W]          = ar_id;
            slave_ar_addr[lane*`AXI_ADDR_W +: `AXI_ADDR_W]    = ar_addr;
            slave_ar_len[lane*`AXI_LEN_W +: `AXI_LEN_W]       = ar_len;
            slave_ar_size[lane*`AXI_SIZE_W +: `AXI_SIZE_W]    = ar_size;
            slave_ar_burst[lane*`AXI_BURST_W +: `AXI_BURST_W] = ar_burst;
            slave_ar_valid[lane]                              = ar_valid;
            slave_r_ready[lane]                               = r_ready;

            ar_ready = slave_ar_ready[lane];
            r_id     = slave_r_id[lane*`AXI_ID_W +: `AXI_ID_W];
            r_data   = slave_r_data[lane*`AXI_DATA_W +: `AXI_DATA_W];
            r_resp   = slave_r_resp[lane*`AXI_RESP_W +: `AXI_RESP_W];
            r_last   = slave_r_last[lane];
            r_valid  = slave_r_valid[lane];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axi_write_router.sv ====
// Write path of the AXI switch: steers AW and W to one slave lane and
// returns that lane's B response. Purely combinational.
`timescale 1ns/1ns
`default_nettype none

`include "axi_switch_macros.svh"

module axi_write_router
    import axi_switch_pkg::*;
(
    input  wire                                   reset,
    input  wire  [`SLAVE_NUM-1:0]                 write_select,

    input  wire  [`AXI_ID_W-1:0]                  aw_id,
    input  wire  [`AXI_ADDR_W-1:0]                aw_addr,
    input  wire  [`AXI_LEN_W-1:0]                 aw_len,
    input  wire  [`AXI_SIZE_W-1:0]                aw_size,
    input  wire  [`AXI_BURST_W-1:0]               aw_burst,
    input  wire                                   aw_valid,
    output logic                                  aw_ready,

    input  wire  [`AXI_DATA_W-1:0]                w_data,
    input  wire  [`AXI_STRB_W-1:0]                w_strb,
    input  wire                                   w_last,
    input  wire                                   w_valid,
    output logic                                  w_ready,

    output logic [`AXI_ID_W-1:0]                  b_id,
    output logic [`AXI_RESP_W-1:0]                b_resp,
    output logic                                  b_valid,
    input  wire                                   b_ready,

    output logic [`AXI_ID_W*`SLAVE_NUM-1:0]       slave_aw_id,
    output logic [`AXI_ADDR_W*`SLAVE_NUM-1:0]     slave_aw_addr,
    output logic [`AXI_LEN_W*`SLAVE_NUM-1:0]      slave_aw_len,
    output logic [`AXI_SIZE_W*`SLAVE_NUM-1:0]     slave_aw_size,
    output logic [`AXI_BURST_W*`SLAVE_NUM-1:0]    slave_aw_burst,
    output logic [`SLAVE_NUM-1:0]                 slave_aw_valid,
    input  wire  [`SLAVE_NUM-1:0]                 slave_aw_ready,

    output logic [`AXI_DATA_W*`SLAVE_NUM-1:0]     slave_w_data,
    output logic [`AXI_STRB_W*`SLAVE_NUM-1:0]     slave_w_strb,
    output logic [`SLAVE_NUM-1:0]                 slave_w_last,
    output logic [`SLAVE_NUM-1:0]                 slave_w_valid,
    input  wire  [`SLAVE_NUM-1:0]                 slave_w_ready,

    input  wire  [`AXI_ID_W*`SLAVE_NUM-1:0]       slave_b_id,
    input  wire  [`AXI_RESP_W*`SLAVE_NUM-1:0]     slave_b_resp,
    input  wire  [`SLAVE_NUM-1:0]                 slave_b_valid,
    output logic [`SLAVE_NUM-1:0]                 slave_b_ready
);

    slave_sel_e target;
    logic [1:0] lane;

    assign target = decode_select(write_select, reset);
    assign lane   = target;

    always_comb begin
        // unselected lanes stay quiet
        slave_aw_id    = '0;
        slave_aw_addr  = '0;
        slave_aw_len   = '0;
        slave_aw_size  = '0;
        slave_aw_burst = '0;
        slave_aw_valid = '0;
        slave_w_data   = '0;
        slave_w_strb   = '0;
        slave_w_last   = '0;
        slave_w_valid  = '0;
        slave_b_ready  = '0;

        // default sink: accept everything and answer OKAY
        aw_ready = 1'b1;
        w_ready  = 1'b1;
        b_id     = '0;
        b_resp   = OKAY;
        b_valid  = 1'b1;

        if (target != SEL_NONE) begin
            slave_aw_id[lane*`AXI_ID_W +: `AXI_ID_W]          = aw_id;
            slave_aw_addr[lane*`AXI_ADDR_W +: `AXI_ADDR_W]    = aw_addr;
            slave_aw_len[lane*`AXI_LEN_W +: `AXI_LEN_W]       = aw_len;
            slave_aw_size[lane*`AXI_SIZE_W +: `AXI_SIZE_W]    = aw_size;
            slave_aw_burst[lane*`AXI_BURST_W +: `AXI_BURST_W] = aw_burst;
            slave_aw_valid[lane]                              = aw_valid;

            slave_w_data[lane*`AXI_DATA_W +: `AXI_DATA_W]     = w_data;
            slave_w_strb[lane*`AXI_STRB_W +: `AXI_STRB_W]     = w_strb;
            slave_w_last[lane]                                = w_last;
            slave_w_valid[lane]                               = w_valid;

            slave_b_ready[lane] = b_ready;

            aw_ready = slave_aw_ready[lane];
            w_ready  = slave_w_ready[lane];
            b_id     = slave_b_id[lane*`AXI_ID_W +: `AXI_ID_W];
            b_resp   = slave_b_resp[lane*`AXI_RESP_W +: `AXI_RESP_W];
            b_valid  = slave_b_valid[lane];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/soc_axi_switch.sv ====
// Top of the SoC AXI4 switch: one master, slaves IO, timer and memory.
// Write and read paths are steered independently by their own selects.
`timescale 1ns/1ns
`default_nettype none

`include "axi_switch_macros.svh"

module soc_axi_switch (
    input  wire                                reset,
    input  wire  [`SLAVE_NUM-1:0]              write_select,
    input  wire  [`SLAVE_NUM-1:0]              read_select,

    // master write address and data
    input  wire  [`AXI_ID_W-1:0]               aw_id,
    input  wire  [`AXI_ADDR_W-1:0]             aw_addr,
    input  wire  [`AXI_LEN_W-1:0]              aw_len,
    input  wire  [`AXI_SIZE_W-1:0]             aw_size,
    input  wire  [`AXI_BURST_W-1:0]            aw_burst,
    input  wire                                aw_valid,
    output wire                                aw_ready,
    input  wire  [`AXI_DATA_W-1:0]             w_data,
    input  wire  [`AXI_STRB_W-1:0]             w_strb,
    input  wire                                w_last,
    input  wire                                w_valid,
    output wire                                w_ready,
    output wire  [`AXI_ID_W-1:0]               b_id,
    output wire  [`AXI_RESP_W-1:0]             b_resp,
    output wire                                b_valid,
    input  wire                                b_ready,

    // master read
    input  wire  [`AXI_ID_W-1:0]               ar_id,
    input  wire  [`AXI_ADDR_W-1:0]             ar_addr,
    input  wire  [`AXI_LEN_W-1:0]              ar_len,
    input  wire  [`AXI_SIZE_W-1:0]             ar_size,
    input  wire  [`AXI_BURST_W-1:0]            ar_burst,
    input  wire                                ar_valid,
    output wire                                ar_ready,
    output wire  [`AXI_ID_W-1:0]               r_id,
    output wire  [`AXI_DATA_W-1:0]             r_data,
    output wire  [`AXI_RESP_W-1:0]             r_resp,
    output wire                                r_last,
    output wire                                r_valid,
    input  wire                                r_ready,

    // slave lanes, lane k at slice k
    output wire  [`AXI_ID_W*`SLAVE_NUM-1:0]    slave_aw_id,
    output wire  [`AXI_ADDR_W*`SLAVE_NUM-1:0]  slave_aw_addr,
    output wire  [`AXI_LEN_W*`SLAVE_NUM-1:0]   slave_aw_len,
    output wire  [`AXI_SIZE_W*`SLAVE_NUM-1:0]  slave_aw_size,
    output wire  [`AXI_BURST_W*`SLAVE_NUM-1:0] slave_aw_burst,
    output wire  [`SLAVE_NUM-1:0]              slave_aw_valid,
    input  wire  [`SLAVE_NUM-1:0]              slave_aw_ready,
    output wire  [`AXI_DATA_W*`SLAVE_NUM-1:0]  slave_w_data,
    output wire  [`AXI_STRB_W*`SLAVE_NUM-1:0]  slave_w_strb,
    output wire  [`SLAVE_NUM-1:0]              slave_w_last,
    output wire  [`SLAVE_NUM-1:0]              slave_w_valid,
    input  wire  [`SLAVE_NUM-1:0]              slave_w_ready,
    input  wire  [`AXI_ID_W*`SLAVE_NUM-1:0]    slave_b_id,
    input  wire  [`AXI_RESP_W*`SLAVE_NUM-1:0]  slave_b_resp,
    input  wire  [`SLAVE_NUM-1:0]              slave_b_valid,
    output wire  [`SLAVE_NUM-1:0]              slave_b_ready,

    output wire  [`AXI_ID_W*`SLAVE_NUM-1:0]    slave_ar_id,
    output wire  [`AXI_ADDR_W*`SLAVE_NUM-1:0]  slave_ar_addr,
    output wire  [`AXI_LEN_W*`SLAVE_NUM-1:0]   slave_ar_len,
    output wire  [`AXI_SIZE_W*`SLAVE_NUM-1:0]  slave_ar_size,
    output wire  [`AXI_BURST_W*`SLAVE_NUM-1:0] slave_ar_burst,
    output wire  [`SLAVE_NUM-1:0]              slave_ar_valid,
    input  wire  [`SLAVE_NUM-1:0]              slave_ar_ready,
    input  wire  [`AXI_ID_W*`SLAVE_NUM-1:0]    slave_r_id,
    input  wire  [`AXI_DATA_W*`SLAVE_NUM-1:0]  slave_r_data,
    input  wire  [`AXI_RESP_W*`SLAVE_NUM-1:0]  slave_r_resp,
    input  wire  [`SLAVE_NUM-1:0]              slave_r_last,
    input  wire  [`SLAVE_NUM-1:0]              slave_r_valid,
    output wire  [`SLAVE_NUM-1:0]              slave_r_ready
);

    // port names match the routers one for one
    axi_write_router i_axi_write_router (.*);

    axi_read_router i_axi_read_router (.*);

endmodule

`default_nettype wire
